// ==== verilog/predecode_pkg.sv ====
// Shared definitions for the block-transfer pre-decoder.
// Holds the register numbering, the phase and scanner command encodings
// and the micro-op record. Every RTL block and the testbench refer to
// these by scoped names.

package predecode_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Register numbering.
        ////////////////////////////////////////////////////////////////////////////

        // Architectural register number.
        // 0..15 are the ARM registers, 16 and 17 are scratch registers,
        // 18..24 are the user-bank copies of r8..r14.
        typedef logic [4:0] arch_reg_t;

        localparam arch_reg_t REG_PC        = 5'd15;
        localparam arch_reg_t DUMMY_REG0    = 5'd16;
        localparam arch_reg_t DUMMY_REG1    = 5'd17;

        // User-bank r8 lives here, r9..r14 follow in order.
        localparam arch_reg_t USR_BANK_BASE = 5'd18;

        ////////////////////////////////////////////////////////////////////////////
        // Offsets and instruction classes.
        ////////////////////////////////////////////////////////////////////////////

        // Byte step per transferred register.
        // Also the immediate of every single-register transfer.
        localparam logic [11:0] WORD_BYTES    = 12'd4;

        // Class code of LDM/STM in bits 27:25.
        localparam logic [2:0]  BLOCK_XFER_ID = 3'b100;

        ////////////////////////////////////////////////////////////////////////////
        // Encodings.
        ////////////////////////////////////////////////////////////////////////////

        // Micro-op kinds seen by decode.
        typedef enum logic [2:0] {
                UOP_PASS,
                UOP_MOV,
                UOP_SUB,
                UOP_LDR,
                UOP_STR,
                UOP_NOP
        } uop_kind_e;

        // Sequencer phase, also selects what the builder emits.
        typedef enum logic [1:0] {
                PH_PASS,
                PH_BASE_SAVE,
                PH_MEMOP,
                PH_WRITE_PC
        } seq_phase_e;

        // Command to the register-list scanner.
        typedef enum logic [1:0] {
                SCAN_HOLD,
                SCAN_LOAD,
                SCAN_NEXT,
                SCAN_CLEAR
        } scan_cmd_e;

        // Outgoing micro-op.
        // MOV copies rn into rd, SUB computes rd = rn - imm.
        // raw only carries meaning on UOP_PASS.
        typedef struct packed {
                uop_kind_e   kind;
                logic [3:0]  cond;
                arch_reg_t   rd;
                arch_reg_t   rn;
                logic [11:0] imm;
                logic        pre;
                logic        wb;
                logic        s;
                logic [31:0] raw;
        } uop_t;

endpackage

// ==== verilog/block_xfer_ctrl.sv ====
// Phase sequencer of the block-transfer pre-decoder.
// Spots LDM/STM in the pass phase, steps through base save, the memory
// ops and the optional PC write, stalls fetch and masks interrupts.
// Sole owner of the flush and downstream stall inputs.

`timescale 1ns/1ps

module block_xfer_ctrl
(
        // Clock and reset.
        input  logic                       i_clk,
        input  logic                       i_reset,

        // Pipeline control.
        input  logic                       i_clear,
        input  logic                       i_stall,

        // Live instruction fields.
        input  logic [2:0]                 i_instr_id,
        input  logic                       i_instr_valid,
        input  logic                       i_load,
        input  logic                       i_pc_listed,

        // Scanner status.
        input  logic                       i_list_empty,

        // Interrupts from fetch.
        input  logic                       i_irq,
        input  logic                       i_fiq,

        // Phase to the builder and command to the scanner.
        output predecode_pkg::seq_phase_e  o_phase,
        output predecode_pkg::scan_cmd_e   o_scan_cmd,

        // Fetch hold and masked interrupts.
        output logic                       o_stall,
        output logic                       o_irq,
        output logic                       o_fiq
);

predecode_pkg::seq_phase_e phase_ff;
predecode_pkg::seq_phase_e phase_nxt;
logic                      start;

// A valid LDM/STM opens a sequence.
assign start = i_instr_valid && (i_instr_id == predecode_pkg::BLOCK_XFER_ID);

////////////////////////////////////////////////////////////////////////////
// Next phase and outputs.
////////////////////////////////////////////////////////////////////////////

always_comb
begin
        phase_nxt  = predecode_pkg::PH_PASS;
        o_phase    = phase_ff;
        o_scan_cmd = predecode_pkg::SCAN_HOLD;
        o_stall    = 1'b0;
        o_irq      = 1'b0;
        o_fiq      = 1'b0;

        case (phase_ff)
        predecode_pkg::PH_MEMOP:
        begin
                // One transfer per cycle, then the restore slot.
                o_scan_cmd = predecode_pkg::SCAN_NEXT;
                if (!i_list_empty)
                begin
                        phase_nxt = predecode_pkg::PH_MEMOP;
                        o_stall   = 1'b1;
                end
                else if (i_load && i_pc_listed)
                begin
                        // PC still has to be written from scratch reg.
                        phase_nxt = predecode_pkg::PH_WRITE_PC;
                        o_stall   = 1'b1;
                end
        end

        predecode_pkg::PH_WRITE_PC:
        begin
                // Last micro-op, fetch is released.
                phase_nxt = predecode_pkg::PH_PASS;
        end

        default:
        begin
                // Interrupts ride on the first micro-op only.
                o_phase = predecode_pkg::PH_PASS;
                o_irq   = i_irq;
                o_fiq   = i_fiq;
                if (start)
                begin
                        // Base save goes out now, list is captured.
                        o_phase    = predecode_pkg::PH_BASE_SAVE;
                        phase_nxt  = predecode_pkg::PH_MEMOP;
                        o_scan_cmd = predecode_pkg::SCAN_LOAD;
                        o_stall    = 1'b1;
                end
        end
        endcase

        // Flush wins over stall.
        if (i_reset || i_clear)
        begin
                o_scan_cmd = predecode_pkg::SCAN_CLEAR;
        end
        else if (i_stall)
        begin
                o_scan_cmd = predecode_pkg::SCAN_HOLD;
        end
end

////////////////////////////////////////////////////////////////////////////
// Phase register.
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                phase_ff <= predecode_pkg::PH_PASS;
        end
        else if (!i_stall)
        begin
                phase_ff <= phase_nxt;
        end
end

endmodule

// ==== verilog/reglist_scanner.sv ====
// Register-list scanner for block transfers.
// Keeps the registers still to transfer, names the lowest one and
// gives the byte size of the whole block from the live instruction.

`timescale 1ns/1ps

module reglist_scanner
(
        input  logic                     i_clk,

        // Command from the sequencer.
        input  predecode_pkg::scan_cmd_e i_cmd,

        // Register list of the live instruction.
        input  logic [15:0]              i_list,

        // Lowest pending register and list status.
        output logic [3:0]               o_lowest_reg,
        output logic                     o_list_empty,

        // Size of the block in bytes.
        output logic [11:0]              o_block_offset
);

logic [15:0] list_ff;
logic [4:0]  ones;

////////////////////////////////////////////////////////////////////////////
// Pending list.
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        case (i_cmd)
        predecode_pkg::SCAN_LOAD:  list_ff <= i_list;
        // Drop the lowest set bit.
        predecode_pkg::SCAN_NEXT:  list_ff <= list_ff & (list_ff - 16'd1);
        predecode_pkg::SCAN_CLEAR: list_ff <= 16'd0;
        default:                   list_ff <= list_ff;
        endcase
end

assign o_list_empty = (list_ff == 16'd0);

// Priority encoder, lowest set bit wins.
// Gives 0 on an empty list.
always_comb
begin
        o_lowest_reg = 4'd0;
        for (int i = 15; i >= 0; i--)
        begin
                if (list_ff[i])
                begin
                        o_lowest_reg = i[3:0];
                end
        end
end

////////////////////////////////////////////////////////////////////////////
// Block size.
////////////////////////////////////////////////////////////////////////////

// Count of listed registers.
always_comb
begin
        ones = 5'd0;
        for (int i = 0; i < 16; i++)
        begin
                ones = ones + {4'd0, i_list[i]};
        end
end

// Fetch holds the instruction, so the live list is stable.
assign o_block_offset = {7'd0, ones} * predecode_pkg::WORD_BYTES;

endmodule

// ==== verilog/uop_builder.sv ====
// Micro-op builder of the block-transfer pre-decoder.
// Turns the current phase, the instruction fields and the scanner
// outputs into one micro-op. Purely combinational.

`timescale 1ns/1ps

module uop_builder
(
        // Phase from the sequencer.
        input  predecode_pkg::seq_phase_e i_phase,

        // Instruction from fetch.
        input  logic [31:0]               i_instruction,
        input  logic                      i_instr_valid,

        // Scanner results.
        input  logic [3:0]                i_lowest_reg,
        input  logic                      i_list_empty,
        input  logic [11:0]               i_block_offset,

        // Outgoing micro-op.
        output predecode_pkg::uop_t       o_uop,
        output logic                      o_uop_valid
);

// Instruction fields.
logic [3:0]               cond;
logic                     pre_index;
logic                     up;
logic                     s_bit;
logic                     writeback;
logic                     load;
predecode_pkg::arch_reg_t base;
logic [15:0]              reglist;

// Register picked for the transfer, after banking.
predecode_pkg::arch_reg_t xfer_reg;
logic                     force_user;

assign cond      = i_instruction[31:28];
assign pre_index = i_instruction[24];
assign up        = i_instruction[23];
assign s_bit     = i_instruction[22];
assign writeback = i_instruction[21];
assign load      = i_instruction[20];
assign base      = {1'b0, i_instruction[19:16]};
assign reglist   = i_instruction[15:0];

////////////////////////////////////////////////////////////////////////////
// Register mapping.
////////////////////////////////////////////////////////////////////////////

// S on a store, or on a load without PC, means user-bank access.
assign force_user = s_bit && (!load || !reglist[15]);

always_comb
begin
        xfer_reg = {1'b0, i_lowest_reg};
        if (force_user)
        begin
                // r8..r14 go to the user copies, offset by r - 8.
                if (i_lowest_reg >= 4'd8 && i_lowest_reg <= 4'd14)
                begin
                        xfer_reg = predecode_pkg::USR_BANK_BASE +
                                   {2'd0, i_lowest_reg[2:0]};
                end
        end
        else if (load && i_lowest_reg == 4'd15)
        begin
                // PC is parked in a scratch register until the end.
                xfer_reg = predecode_pkg::DUMMY_REG1;
        end
end

////////////////////////////////////////////////////////////////////////////
// Micro-op per phase.
////////////////////////////////////////////////////////////////////////////

always_comb
begin
        o_uop       = '0;
        o_uop.cond  = cond;
        o_uop_valid = 1'b1;

        case (i_phase)
        predecode_pkg::PH_BASE_SAVE:
        begin
                // Increment modes copy the base.
                // Decrement modes start at base - block size.
                o_uop.rd = predecode_pkg::DUMMY_REG0;
                o_uop.rn = base;
                if (up)
                begin
                        o_uop.kind = predecode_pkg::UOP_MOV;
                end
                else
                begin
                        o_uop.kind = predecode_pkg::UOP_SUB;
                        o_uop.imm  = i_block_offset;
                end
        end

        predecode_pkg::PH_MEMOP:
        begin
                if (!i_list_empty)
                begin
                        // DA becomes IB and DB becomes IA.
                        // Writeback only on pre-index, post-index has it built in.
                        o_uop.kind = load ? predecode_pkg::UOP_LDR :
                                            predecode_pkg::UOP_STR;
                        o_uop.rd   = xfer_reg;
                        o_uop.rn   = predecode_pkg::DUMMY_REG0;
                        o_uop.imm  = predecode_pkg::WORD_BYTES;
                        o_uop.pre  = pre_index ^ ~up;
                        o_uop.wb   = pre_index ^ ~up;
                end
                else if (writeback && up)
                begin
                        // Final address is in the scratch base.
                        o_uop.kind = predecode_pkg::UOP_MOV;
                        o_uop.rd   = base;
                        o_uop.rn   = predecode_pkg::DUMMY_REG0;
                end
                else if (writeback)
                begin
                        o_uop.kind = predecode_pkg::UOP_SUB;
                        o_uop.rd   = base;
                        o_uop.rn   = base;
                        o_uop.imm  = i_block_offset;
                end
                else
                begin
                        // Empty slot.
                        o_uop.kind = predecode_pkg::UOP_NOP;
                end
        end

        predecode_pkg::PH_WRITE_PC:
        begin
                // With S set this is the exception return.
                o_uop.kind = predecode_pkg::UOP_MOV;
                o_uop.rd   = predecode_pkg::REG_PC;
                o_uop.rn   = predecode_pkg::DUMMY_REG1;
                o_uop.s    = s_bit;
        end

        default:
        begin
                o_uop.kind  = predecode_pkg::UOP_PASS;
                o_uop.cond  = 4'd0;
                o_uop.raw   = i_instruction;
                o_uop_valid = i_instr_valid;
        end
        endcase
end

endmodule

// ==== verilog/mem_predecode.sv ====
// Block-transfer pre-decoder, top level.
// Sits between fetch and decode and expands LDM/STM into single
// transfers. Only connects the sequencer, scanner and builder.

`timescale 1ns/1ps

module mem_predecode
(
        // Clock and reset.
        input  logic                i_clk,
        input  logic                i_reset,

        // Pipeline control.
        input  logic                i_clear,
        input  logic                i_stall,

        // From fetch.
        input  logic [31:0]         i_instruction,
        input  logic                i_instr_valid,
        input  logic                i_irq,
        input  logic                i_fiq,

        // To decode.
        output predecode_pkg::uop_t o_uop,
        output logic                o_uop_valid,
        output logic                o_stall,
        output logic                o_irq,
        output logic                o_fiq
);

predecode_pkg::seq_phase_e phase;
predecode_pkg::scan_cmd_e  scan_cmd;
logic [3:0]                lowest_reg;
logic                      list_empty;
logic [11:0]               block_offset;

// Sequencer, sees class, L bit and r15 in the list.
block_xfer_ctrl u_ctrl
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_clear        (i_clear),
        .i_stall        (i_stall),
        .i_instr_id     (i_instruction[27:25]),
        .i_instr_valid  (i_instr_valid),
        .i_load         (i_instruction[20]),
        .i_pc_listed    (i_instruction[15]),
        .i_list_empty   (list_empty),
        .i_irq          (i_irq),
        .i_fiq          (i_fiq),
        .o_phase        (phase),
        .o_scan_cmd     (scan_cmd),
        .o_stall        (o_stall),
        .o_irq          (o_irq),
        .o_fiq          (o_fiq)
);

reglist_scanner u_scan
(
        .i_clk          (i_clk),
        .i_cmd          (scan_cmd),
        .i_list         (i_instruction[15:0]),
        .o_lowest_reg   (lowest_reg),
        .o_list_empty   (list_empty),
        .o_block_offset (block_offset)
);

uop_builder u_build
(
        .i_phase        (phase),
        .i_instruction  (i_instruction),
        .i_instr_valid  (i_instr_valid),
        .i_lowest_reg   (lowest_reg),
        .i_list_empty   (list_empty),
        .i_block_offset (block_offset),
        .o_uop          (o_uop),
        .o_uop_valid    (o_uop_valid)
);

endmodule

// ==== verif/tb_mem_predecode.sv ====
// Testbench for the block-transfer pre-decoder.
// Drives pass-through and LDM/STM instructions from an LFSR, expands each
// one with a reference model and compares every micro-op, the stall and
// the interrupt outputs on the rising edge. Stops at the first mismatch.

`timescale 1ns/1ps

module tb_mem_predecode;

localparam logic [31:0] SEED         = 32'h2b22_9aee;
localparam int          N_INSTR      = 136;
localparam int          WATCH_CYCLES = N_INSTR * 60 + 100;

logic                i_clk = 1'b0;
logic                i_reset;
logic                i_clear;
logic                i_stall;
logic [31:0]         i_instruction;
logic                i_instr_valid;
logic                i_irq;
logic                i_fiq;
predecode_pkg::uop_t o_uop;
logic                o_uop_valid;
logic                o_stall;
logic                o_irq;
logic                o_fiq;

// Driver side of the handshake with the compare process.
logic [31:0]         lfsr_state  = SEED;
logic                stall_en    = 1'b0;
string               cur_name    = "";
logic [31:0]         cur_instr   = 32'd0;
logic                cur_valid   = 1'b0;
int                  cur_len     = 0;
int                  started_id  = 0;

// Compare side.
int                  finished_id = 0;
int                  idx         = 0;
int                  error_count = 0;
predecode_pkg::uop_t exp_uop;
logic                exp_valid;
logic                exp_stall;
logic                exp_irq;
logic                exp_fiq;

mem_predecode UUT
(
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clear       (i_clear),
        .i_stall       (i_stall),
        .i_instruction (i_instruction),
        .i_instr_valid (i_instr_valid),
        .i_irq         (i_irq),
        .i_fiq         (i_fiq),
        .o_uop         (o_uop),
        .o_uop_valid   (o_uop_valid),
        .o_stall       (o_stall),
        .o_irq         (o_irq),
        .o_fiq         (o_fiq)
);

always #10 i_clk = ~i_clk;

////////////////////////////////////////////////////////////////////////////
// Reference model.
////////////////////////////////////////////////////////////////////////////

// Valid LDM/STM with class 100 in bits 27:25.
function automatic logic is_block(input logic [31:0] instr, input logic valid);
        is_block = valid && (instr[27:25] == 3'b100);
endfunction

function automatic int count_regs(input logic [15:0] list);
        count_regs = 0;
        for (int r = 0; r < 16; r++)
        begin
                count_regs = count_regs + (list[r] ? 1 : 0);
        end
endfunction

// Micro-ops per instruction are the save, N transfers, the restore and maybe a PC write.
function automatic int sequence_len(input logic [31:0] instr, input logic valid);
        if (!is_block(instr, valid))
        begin
                return 1;
        end
        return count_regs(instr[15:0]) + 2 + ((instr[20] && instr[15]) ? 1 : 0);
endfunction

// Micro-op number idx of the expansion of instr.
function automatic predecode_pkg::uop_t expected_uop(input logic [31:0] instr,
                                                     input logic valid, input int idx);
        predecode_pkg::uop_t u;
        logic [15:0]         list;
        logic                up;
        logic                s_bit;
        logic                load;
        logic [4:0]          rn;
        logic [11:0]         offs;
        int                  cnt;
        int                  k;
        int                  reg_n;
        u     = '0;
        list  = instr[15:0];
        up    = instr[23];
        s_bit = instr[22];
        load  = instr[20];
        rn    = {1'b0, instr[19:16]};
        cnt   = count_regs(list);
        offs  = 12'(cnt * 4);
        if (!is_block(instr, valid))
        begin
                u.kind = predecode_pkg::UOP_PASS;
                u.raw  = instr;
                return u;
        end
        u.cond = instr[31:28];
        if (idx == 0)
        begin
                // Decrement modes start one block below the base.
                u.kind = up ? predecode_pkg::UOP_MOV : predecode_pkg::UOP_SUB;
                u.rd   = predecode_pkg::DUMMY_REG0;
                u.rn   = rn;
                u.imm  = up ? 12'd0 : offs;
        end
        else if (idx <= cnt)
        begin
                // Register number idx counted from the lowest.
                k     = 0;
                reg_n = 0;
                for (int r = 0; r < 16; r++)
                begin
                        if (list[r])
                        begin
                                k = k + 1;
                                if (k == idx)
                                begin
                                        reg_n = r;
                                end
                        end
                end
                u.kind = load ? predecode_pkg::UOP_LDR : predecode_pkg::UOP_STR;
                u.rd   = 5'(reg_n);
                if (s_bit && (!load || !list[15]) && reg_n >= 8 && reg_n <= 14)
                begin
                        u.rd = predecode_pkg::USR_BANK_BASE + 5'(reg_n - 8);
                end
                else if (load && reg_n == 15)
                begin
                        u.rd = predecode_pkg::DUMMY_REG1;
                end
                u.rn  = predecode_pkg::DUMMY_REG0;
                u.imm = predecode_pkg::WORD_BYTES;
                // IA and IB keep P, DA turns into IB and DB into IA.
                u.pre = up ? instr[24] : !instr[24];
                u.wb  = u.pre;
        end
        else if (idx == cnt + 1)
        begin
                // Restore by W and U, or an empty slot.
                u.kind = !instr[21] ? predecode_pkg::UOP_NOP :
                         up ? predecode_pkg::UOP_MOV : predecode_pkg::UOP_SUB;
                u.rd   = instr[21] ? rn : 5'd0;
                u.rn   = !instr[21] ? 5'd0 : up ? predecode_pkg::DUMMY_REG0 : rn;
                u.imm  = (instr[21] && !up) ? offs : 12'd0;
        end
        else
        begin
                u.kind = predecode_pkg::UOP_MOV;
                u.rd   = predecode_pkg::REG_PC;
                u.rn   = predecode_pkg::DUMMY_REG1;
                u.s    = s_bit;
        end
        return u;
endfunction

////////////////////////////////////////////////////////////////////////////
// Checking.
////////////////////////////////////////////////////////////////////////////

task automatic check_value(input string test, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act)
        begin
                error_count = error_count + 1;
                $display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
                $display("=== FAIL ===");
                $fatal(1, "stopped at first mismatch");
        end
endtask

// Every unstalled edge of an open instruction yields its next micro-op.
always @(posedge i_clk)
begin
        if (!i_reset && finished_id != started_id)
        begin
                if (i_clear)
                begin
                        idx         = 0;
                        finished_id = started_id;
                end
                else if (!i_stall)
                begin
                        exp_uop   = expected_uop(cur_instr, cur_valid, idx);
                        exp_valid = is_block(cur_instr, cur_valid) ? 1'b1 : cur_valid;
                        exp_stall = (idx != cur_len - 1);
                        exp_irq   = (idx == 0) ? i_irq : 1'b0;
                        exp_fiq   = (idx == 0) ? i_fiq : 1'b0;
                        check_value(cur_name, $sformatf("uop %0d", idx), exp_uop, o_uop);
                        check_value(cur_name, "valid", 64'(exp_valid), 64'(o_uop_valid));
                        check_value(cur_name, "stall", 64'(exp_stall), 64'(o_stall));
                        check_value(cur_name, "irq", 64'(exp_irq), 64'(o_irq));
                        check_value(cur_name, "fiq", 64'(exp_fiq), 64'(o_fiq));
                        idx = idx + 1;
                        if (idx == cur_len)
                        begin
                                idx         = 0;
                                finished_id = started_id;
                        end
                end
        end
end

////////////////////////////////////////////////////////////////////////////
// Stimulus.
////////////////////////////////////////////////////////////////////////////

// Fibonacci LFSR with taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken.
task automatic draw_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++)
        begin
                lfsr_state = lfsr_next(lfsr_state);
                v          = {v[30:0], lfsr_state[0]};
        end
endtask

// Random instruction outside the block-transfer class.
task automatic make_plain(output logic [31:0] instr);
        draw_bits(32, instr);
        if (instr[27:25] == 3'b100)
        begin
                instr[25] = 1'b1;
        end
endtask

// Mode 0 is U set, 1 is U clear, 2 is S and r15 mixes, 3 is all random.
task automatic make_block(input int mode, input logic [15:0] force_bits,
                          output logic [31:0] instr);
        logic [31:0] r;
        logic [15:0] list;
        logic        up;
        logic        s_bit;
        draw_bits(16, r);
        list = r[15:0] | force_bits;
        if (list == 16'd0)
        begin
                list = 16'h0001;
        end
        draw_bits(14, r);
        up    = (mode == 0) ? 1'b1 : (mode == 1) ? 1'b0 : r[7];
        s_bit = (mode >= 2) ? r[6] : 1'b0;
        if (mode == 2)
        begin
                list[15] = r[13];
        end
        instr = {r[3:0], 3'b100, r[4], up, s_bit, r[5], r[8], r[12:9], list};
endtask

// Per-cycle inputs that are set on the falling edge.
task automatic drive_cycle(input int clear_at);
        logic [31:0] r;
        draw_bits(4, r);
        i_irq   = r[0];
        i_fiq   = r[1];
        i_stall = stall_en && (r[3:2] == 2'd0);
        if (clear_at >= 0 && idx == clear_at)
        begin
                // On odd slots a stall comes with the flush and must lose.
                i_clear = 1'b1;
                i_stall = ((clear_at % 2) == 1);
        end
endtask

// Fetch holds the instruction until its last micro-op is taken.
task automatic run_instr(input string name, input logic [31:0] instr,
                         input logic valid, input int clear_at);
        cur_name      = name;
        cur_instr     = instr;
        cur_valid     = valid;
        cur_len       = sequence_len(instr, valid);
        i_instruction = instr;
        i_instr_valid = valid;
        started_id    = started_id + 1;
        while (finished_id != started_id)
        begin
                drive_cycle(clear_at);
                @(negedge i_clk);
        end
        i_clear = 1'b0;
        i_stall = 1'b0;
endtask

initial
begin
        logic [31:0] instr;
        logic [31:0] r;
        i_reset       = 1'b1;
        i_clear       = 1'b0;
        i_stall       = 1'b0;
        i_instruction = 32'd0;
        i_instr_valid = 1'b0;
        i_irq         = 1'b0;
        i_fiq         = 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        // Pass-through with a few bubbles.
        for (int n = 0; n < 40; n++)
        begin
                make_plain(instr);
                draw_bits(3, r);
                run_instr("pass_through", instr, r[2:0] != 3'd0, -1);
        end
        for (int n = 0; n < 20; n++)
        begin
                make_block(0, 16'd0, instr);
                run_instr("block_up", instr, 1'b1, -1);
        end
        for (int n = 0; n < 20; n++)
        begin
                make_block(1, 16'd0, instr);
                run_instr("block_down", instr, 1'b1, -1);
        end
        for (int n = 0; n < 24; n++)
        begin
                make_block(2, 16'h4100, instr);
                run_instr("user_bank_pc", instr, 1'b1, -1);
        end

        // Downstream stall pulses.
        stall_en = 1'b1;
        for (int n = 0; n < 24; n++)
        begin
                make_block(3, 16'd0, instr);
                run_instr("stall_random", instr, 1'b1, -1);
        end
        stall_en = 1'b0;

        // Flush in mid-sequence, then a plain instruction.
        for (int n = 0; n < 4; n++)
        begin
                make_block(3, 16'h00f0, instr);
                run_instr("clear_mid", instr, 1'b1, 2 + (n % 2));
                make_plain(instr);
                run_instr("after_clear", instr, 1'b1, -1);
        end

        @(negedge i_clk);
        if (error_count == 0)
        begin
                $display("=== PASS ===");
                $finish;
        end
        else
        begin
                $display("=== FAIL ===");
                $fatal(1, "errors were found");
        end
end

// Watchdog allows about 60 cycles per instruction plus margin.
initial
begin
        repeat (WATCH_CYCLES) @(posedge i_clk);
        $display("Watchdog: run did not finish within %0d cycles, giving up.", WATCH_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
end

endmodule

// ==== compile.f ====
verilog/predecode_pkg.sv
verilog/block_xfer_ctrl.sv
verilog/reglist_scanner.sv
verilog/uop_builder.sv
verilog/mem_predecode.sv
verif/tb_mem_predecode.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pre-decoder testbench with Verilator and run it.
# The exit status of the simulation is the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f compile.f --top-module tb_mem_predecode -o sim_tb

./obj_dir/sim_tb
